/* hw/csr_pkg.sv */
package csr_pkg;

// --------------------------------------------------
// widths and basic types
localparam int unsigned ARCH_WIDTH = 32;
localparam int unsigned CSR_ADDR_WIDTH = 12;

typedef logic [ARCH_WIDTH-1:0] arch_width_t;
// 64-bit counter, word 0 is the low half
typedef arch_width_t [1:0] csr_dw_t;
typedef logic [CSR_ADDR_WIDTH-1:0] csr_addr_t;

localparam int unsigned CSR_LOW = 0;
localparam int unsigned CSR_HIGH = 1;

// --------------------------------------------------
// instruction fields
localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;
// funct3 values that are not csr accesses
localparam logic [2:0] FUNCT3_PRIV = 3'b000;
localparam logic [2:0] FUNCT3_RSVD = 3'b100;

// low two bits of funct3, bit 2 selects the immediate form
typedef enum logic [1:0] {
    CSR_OP_RW = 2'b01,
    CSR_OP_RS = 2'b10,
    CSR_OP_RC = 2'b11
} csr_op_t;

// --------------------------------------------------
// performance monitor
localparam int unsigned MHPMCOUNTERS = 6;
localparam int unsigned MHPMEVENTS = 6;
localparam int unsigned MHPM_OFFSET = 3;

// one-hot selector, same bit order as perf_event_t
typedef logic [MHPMEVENTS-1:0] mhpmevent_t;
typedef logic [MHPMEVENTS-1:0] perf_event_t;

localparam mhpmevent_t MHPMEVENT_NONE = 6'b00_0000;
localparam mhpmevent_t MHPMEVENT_BAD_SPEC = 6'b00_0001;
localparam mhpmevent_t MHPMEVENT_BE = 6'b00_0010;
localparam mhpmevent_t MHPMEVENT_BE_DC = 6'b00_0100;
localparam mhpmevent_t MHPMEVENT_FE = 6'b00_1000;
localparam mhpmevent_t MHPMEVENT_FE_IC = 6'b01_0000;
localparam mhpmevent_t MHPMEVENT_RET_SIMD = 6'b10_0000;

// --------------------------------------------------
// csr addresses
localparam csr_addr_t CSR_TOHOST = 12'h51E;
localparam csr_addr_t CSR_MSCRATCH = 12'h340;
localparam csr_addr_t CSR_MCYCLE = 12'hB00;
localparam csr_addr_t CSR_MCYCLEH = 12'hB80;
localparam csr_addr_t CSR_MINSTRET = 12'hB02;
localparam csr_addr_t CSR_MINSTRETH = 12'hB82;
localparam csr_addr_t CSR_TIME = 12'hC01;
localparam csr_addr_t CSR_TIMEH = 12'hC81;

// hpm banks start at index MHPM_OFFSET
localparam csr_addr_t CSR_MHPMCOUNTER3 = CSR_MCYCLE + csr_addr_t'(MHPM_OFFSET);
localparam csr_addr_t CSR_MHPMCOUNTER4 = 12'hB04;
localparam csr_addr_t CSR_MHPMCOUNTER5 = 12'hB05;
localparam csr_addr_t CSR_MHPMCOUNTER6 = 12'hB06;
localparam csr_addr_t CSR_MHPMCOUNTER7 = 12'hB07;
localparam csr_addr_t CSR_MHPMCOUNTER8 = 12'hB08;
localparam csr_addr_t CSR_MHPMCOUNTER3H = CSR_MCYCLEH + csr_addr_t'(MHPM_OFFSET);
localparam csr_addr_t CSR_MHPMCOUNTER4H = 12'hB84;
localparam csr_addr_t CSR_MHPMCOUNTER5H = 12'hB85;
localparam csr_addr_t CSR_MHPMCOUNTER6H = 12'hB86;
localparam csr_addr_t CSR_MHPMCOUNTER7H = 12'hB87;
localparam csr_addr_t CSR_MHPMCOUNTER8H = 12'hB88;
localparam csr_addr_t CSR_MHPMEVENT3 = 12'h320 + csr_addr_t'(MHPM_OFFSET);
localparam csr_addr_t CSR_MHPMEVENT4 = 12'h324;
localparam csr_addr_t CSR_MHPMEVENT5 = 12'h325;
localparam csr_addr_t CSR_MHPMEVENT6 = 12'h326;
localparam csr_addr_t CSR_MHPMEVENT7 = 12'h327;
localparam csr_addr_t CSR_MHPMEVENT8 = 12'h328;

// lookup tables, entry 0 is counter 3
localparam csr_addr_t [MHPMCOUNTERS-1:0] MHPM_CNT_LO_ADDR = {
    CSR_MHPMCOUNTER8, CSR_MHPMCOUNTER7, CSR_MHPMCOUNTER6,
    CSR_MHPMCOUNTER5, CSR_MHPMCOUNTER4, CSR_MHPMCOUNTER3
};
localparam csr_addr_t [MHPMCOUNTERS-1:0] MHPM_CNT_HI_ADDR = {
    CSR_MHPMCOUNTER8H, CSR_MHPMCOUNTER7H, CSR_MHPMCOUNTER6H,
    CSR_MHPMCOUNTER5H, CSR_MHPMCOUNTER4H, CSR_MHPMCOUNTER3H
};
localparam csr_addr_t [MHPMEVENTS-1:0] MHPM_EVT_ADDR = {
    CSR_MHPMEVENT8, CSR_MHPMEVENT7, CSR_MHPMEVENT6,
    CSR_MHPMEVENT5, CSR_MHPMEVENT4, CSR_MHPMEVENT3
};

// --------------------------------------------------
// microsecond timer
localparam int unsigned CLOCK_FREQ = 25_000_000;
localparam int unsigned CLOCKS_PER_US = CLOCK_FREQ / 1_000_000;
localparam int unsigned US_CNT_WIDTH = $clog2(CLOCKS_PER_US);
localparam logic [US_CNT_WIDTH-1:0] US_CNT_LAST = US_CNT_WIDTH'(CLOCKS_PER_US - 1);

endpackage

/* hw/csr_decode.sv */
`timescale 1ns/100ps

module csr_decode (
    input  logic inst_valid,
    input  logic [31:0] inst,
    output logic csr_en,
    output logic csr_re,
    output logic csr_we,
    output logic csr_ui,
    output csr_pkg::csr_op_t csr_op,
    output csr_pkg::csr_addr_t csr_addr,
    output logic [4:0] csr_imm5
);

// --------------------------------------------------
// instruction fields
logic [6:0] opcode;
logic [2:0] funct3;
logic [4:0] rd;
logic [4:0] rs1;

assign opcode = inst[6:0];
assign rd = inst[11:7];
assign funct3 = inst[14:12];
assign rs1 = inst[19:15];

// --------------------------------------------------
// csr access qualification
logic is_system;
logic is_csr_f3;
logic op_is_rw;

assign is_system = (opcode == csr_pkg::OPC_SYSTEM);
// ecall/ebreak/mret and the reserved slot are not csr ops
assign is_csr_f3 = (funct3 != csr_pkg::FUNCT3_PRIV) && (funct3 != csr_pkg::FUNCT3_RSVD);

assign csr_en = inst_valid && is_system && is_csr_f3;

// op encoding follows funct3 directly
assign csr_op = csr_pkg::csr_op_t'(funct3[1:0]);
assign csr_ui = funct3[2];
assign op_is_rw = (csr_op == csr_pkg::CSR_OP_RW);

// rw with rd=x0 must not read
assign csr_re = csr_en && !(op_is_rw && (rd == 5'd0));

// rs/rc with rs1=x0 (or uimm 0) must not write
assign csr_we = csr_en && (op_is_rw || (rs1 != 5'd0));

// same field holds the register index or the zimm
assign csr_addr = inst[31:20];
assign csr_imm5 = rs1;

endmodule

/* hw/csr_us_timer.sv */
`timescale 1ns/100ps

module csr_us_timer (
    input  logic clk,
    input  logic rst,
    output csr_pkg::csr_dw_t mtime
);

// --------------------------------------------------
// prescaler
logic [csr_pkg::US_CNT_WIDTH-1:0] us_cnt;
logic us_tick;

// tick is registered, one cycle after the last count
always_ff @(posedge clk) begin
    if (rst) begin
        us_cnt <= '0;
        us_tick <= 1'b0;
    end else if (us_cnt == csr_pkg::US_CNT_LAST) begin
        us_cnt <= '0;
        us_tick <= 1'b1;
    end else begin
        us_cnt <= us_cnt + 1'b1;
        us_tick <= 1'b0;
    end
end

// --------------------------------------------------
// time counter, read only
always_ff @(posedge clk) begin
    if (rst) begin
        mtime <= '0;
    end else if (us_tick) begin
        mtime <= mtime + 64'd1;
    end
end

endmodule

/* hw/csr_hpm_counters.sv */
`timescale 1ns/100ps

module csr_hpm_counters (
    input  logic clk,
    input  logic rst,
    input  logic we,
    input  csr_pkg::csr_addr_t addr,
    input  csr_pkg::arch_width_t wdata,
    input  csr_pkg::perf_event_t perf_event,
    output csr_pkg::arch_width_t rdata,
    output logic hit
);

// only the defined one-hot codes count anything
function automatic logic event_fired(
    input csr_pkg::perf_event_t pe,
    input csr_pkg::mhpmevent_t sel
);
    case (sel)
        csr_pkg::MHPMEVENT_BAD_SPEC: event_fired = pe[0];
        csr_pkg::MHPMEVENT_BE: event_fired = pe[1];
        csr_pkg::MHPMEVENT_BE_DC: event_fired = pe[2];
        csr_pkg::MHPMEVENT_FE: event_fired = pe[3];
        csr_pkg::MHPMEVENT_FE_IC: event_fired = pe[4];
        csr_pkg::MHPMEVENT_RET_SIMD: event_fired = pe[5];
        default: event_fired = 1'b0;
    endcase
endfunction

// --------------------------------------------------
// address match
logic [csr_pkg::MHPMCOUNTERS-1:0] am_lo;
logic [csr_pkg::MHPMCOUNTERS-1:0] am_hi;
logic [csr_pkg::MHPMEVENTS-1:0] am_evt;

always_comb begin
    for (int i = 0; i < csr_pkg::MHPMCOUNTERS; i++) begin
        am_lo[i] = (addr == csr_pkg::MHPM_CNT_LO_ADDR[i]);
        am_hi[i] = (addr == csr_pkg::MHPM_CNT_HI_ADDR[i]);
    end
    for (int i = 0; i < csr_pkg::MHPMEVENTS; i++) begin
        am_evt[i] = (addr == csr_pkg::MHPM_EVT_ADDR[i]);
    end
end

// --------------------------------------------------
// event selectors
csr_pkg::mhpmevent_t evt_sel [csr_pkg::MHPMEVENTS];

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < csr_pkg::MHPMEVENTS; i++) begin
            evt_sel[i] <= csr_pkg::MHPMEVENT_NONE;
        end
    end else if (we) begin
        for (int i = 0; i < csr_pkg::MHPMEVENTS; i++) begin
            if (am_evt[i]) begin
                evt_sel[i] <= csr_pkg::mhpmevent_t'(wdata[csr_pkg::MHPMEVENTS-1:0]);
            end
        end
    end
end

// --------------------------------------------------
// counters, a write to either half wins over the event
csr_pkg::csr_dw_t cnt [csr_pkg::MHPMCOUNTERS];

for (genvar i = 0; i < csr_pkg::MHPMCOUNTERS; i++) begin : gen_cnt
    csr_pkg::csr_dw_t count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (we && am_lo[i]) begin
            count[csr_pkg::CSR_LOW] <= wdata;
        end else if (we && am_hi[i]) begin
            count[csr_pkg::CSR_HIGH] <= wdata;
        end else if (event_fired(perf_event, evt_sel[i])) begin
            count <= count + 64'd1;
        end
    end

    assign cnt[i] = count;
end

// --------------------------------------------------
// read back
always_comb begin
    rdata = '0;
    hit = 1'b0;
    for (int i = 0; i < csr_pkg::MHPMCOUNTERS; i++) begin
        if (am_lo[i]) begin
            rdata = cnt[i][csr_pkg::CSR_LOW];
            hit = 1'b1;
        end
        if (am_hi[i]) begin
            rdata = cnt[i][csr_pkg::CSR_HIGH];
            hit = 1'b1;
        end
    end
    for (int i = 0; i < csr_pkg::MHPMEVENTS; i++) begin
        if (am_evt[i]) begin
            // selectors are zero extended
            rdata = csr_pkg::arch_width_t'(evt_sel[i]);
            hit = 1'b1;
        end
    end
end

endmodule

/* hw/csr_file.sv */
`timescale 1ns/100ps

module csr_file (
    input  logic clk,
    input  logic rst,
    input  logic csr_en,
    input  logic csr_re,
    input  logic csr_we,
    input  logic csr_ui,
    input  csr_pkg::csr_op_t csr_op,
    input  csr_pkg::csr_addr_t csr_addr,
    input  logic [4:0] csr_imm5,
    input  csr_pkg::arch_width_t rs1_data,
    input  logic retire,
    input  csr_pkg::perf_event_t perf_event,
    output csr_pkg::arch_width_t rdata
);

// --------------------------------------------------
// state and sub-blocks
csr_pkg::arch_width_t tohost;
csr_pkg::arch_width_t mscratch;
csr_pkg::csr_dw_t mcycle;
csr_pkg::csr_dw_t minstret;
csr_pkg::csr_dw_t mtime;

csr_pkg::arch_width_t hpm_rdata;
logic hpm_hit;

csr_pkg::csr_addr_t addr_en;
csr_pkg::arch_width_t old_val;
csr_pkg::arch_width_t wr_src;
csr_pkg::arch_width_t wr_data;

// no match outside a valid csr instruction
assign addr_en = csr_en ? csr_addr : '0;

csr_us_timer csr_us_timer_i (
    .clk   (clk),
    .rst   (rst),
    .mtime (mtime)
);

csr_hpm_counters csr_hpm_counters_i (
    .clk        (clk),
    .rst        (rst),
    .we         (csr_we),
    .addr       (addr_en),
    .wdata      (wr_data),
    .perf_event (perf_event),
    .rdata      (hpm_rdata),
    .hit        (hpm_hit)
);

// --------------------------------------------------
// read mux
always_comb begin
    case (addr_en)
        csr_pkg::CSR_TOHOST: old_val = tohost;
        csr_pkg::CSR_MSCRATCH: old_val = mscratch;
        csr_pkg::CSR_MCYCLE: old_val = mcycle[csr_pkg::CSR_LOW];
        csr_pkg::CSR_MCYCLEH: old_val = mcycle[csr_pkg::CSR_HIGH];
        csr_pkg::CSR_MINSTRET: old_val = minstret[csr_pkg::CSR_LOW];
        csr_pkg::CSR_MINSTRETH: old_val = minstret[csr_pkg::CSR_HIGH];
        csr_pkg::CSR_TIME: old_val = mtime[csr_pkg::CSR_LOW];
        csr_pkg::CSR_TIMEH: old_val = mtime[csr_pkg::CSR_HIGH];
        default: old_val = hpm_hit ? hpm_rdata : '0;
    endcase
end

// rd sees the old value only when the read is enabled
assign rdata = csr_re ? old_val : '0;

// --------------------------------------------------
// read-modify-write data
assign wr_src = csr_ui ? csr_pkg::arch_width_t'(csr_imm5) : rs1_data;

always_comb begin
    case (csr_op)
        csr_pkg::CSR_OP_RW: wr_data = wr_src;
        csr_pkg::CSR_OP_RS: wr_data = old_val | wr_src;
        csr_pkg::CSR_OP_RC: wr_data = old_val & ~wr_src;
        default: wr_data = '0;
    endcase
end

// --------------------------------------------------
// plain registers
always_ff @(posedge clk) begin
    if (rst) begin
        tohost <= '0;
        mscratch <= '0;
    end else if (csr_we) begin
        if (addr_en == csr_pkg::CSR_TOHOST) begin
            tohost <= wr_data;
        end
        if (addr_en == csr_pkg::CSR_MSCRATCH) begin
            mscratch <= wr_data;
        end
    end
end

// --------------------------------------------------
// mcycle, counts every edge it is not written
always_ff @(posedge clk) begin
    if (rst) begin
        mcycle <= '0;
    end else if (csr_we && (addr_en == csr_pkg::CSR_MCYCLE)) begin
        mcycle[csr_pkg::CSR_LOW] <= wr_data;
    end else if (csr_we && (addr_en == csr_pkg::CSR_MCYCLEH)) begin
        mcycle[csr_pkg::CSR_HIGH] <= wr_data;
    end else begin
        mcycle <= mcycle + 64'd1;
    end
end

// minstret, one per retire pulse
always_ff @(posedge clk) begin
    if (rst) begin
        minstret <= '0;
    end else if (csr_we && (addr_en == csr_pkg::CSR_MINSTRET)) begin
        minstret[csr_pkg::CSR_LOW] <= wr_data;
    end else if (csr_we && (addr_en == csr_pkg::CSR_MINSTRETH)) begin
        minstret[csr_pkg::CSR_HIGH] <= wr_data;
    end else if (retire) begin
        minstret <= minstret + 64'd1;
    end
end

endmodule

/* hw/csr_unit_top.sv */
`timescale 1ns/100ps

module csr_unit_top (
    input  logic clk,
    input  logic rst,
    input  logic inst_valid,
    input  logic [31:0] inst,
    input  csr_pkg::arch_width_t rs1_data,
    input  logic retire,
    input  csr_pkg::perf_event_t perf_event,
    output csr_pkg::arch_width_t csr_rdata
);

// --------------------------------------------------
// decoded controls
logic csr_en;
logic csr_re;
logic csr_we;
logic csr_ui;
csr_pkg::csr_op_t csr_op;
csr_pkg::csr_addr_t csr_addr;
logic [4:0] csr_imm5;

csr_decode csr_decode_i (
    .inst_valid (inst_valid),
    .inst       (inst),
    .csr_en     (csr_en),
    .csr_re     (csr_re),
    .csr_we     (csr_we),
    .csr_ui     (csr_ui),
    .csr_op     (csr_op),
    .csr_addr   (csr_addr),
    .csr_imm5   (csr_imm5)
);

// --------------------------------------------------
// register file with timer and hpm
csr_file csr_file_i (
    .clk        (clk),
    .rst        (rst),
    .csr_en     (csr_en),
    .csr_re     (csr_re),
    .csr_we     (csr_we),
    .csr_ui     (csr_ui),
    .csr_op     (csr_op),
    .csr_addr   (csr_addr),
    .csr_imm5   (csr_imm5),
    .rs1_data   (rs1_data),
    .retire     (retire),
    .perf_event (perf_event),
    .rdata      (csr_rdata)
);

endmodule

/* sim/csr_unit_tb.sv */
`timescale 1ns/100ps

module csr_unit_tb;

localparam int MAX_CYCLES = 5000;
localparam int MAX_LINES = 500;

logic clk;
logic rst;
logic inst_valid;
logic [31:0] inst;
csr_pkg::arch_width_t rs1_data;
logic retire;
csr_pkg::perf_event_t perf_event;
csr_pkg::arch_width_t csr_rdata;

csr_unit_top csr_unit_top_i (
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .inst       (inst),
    .rs1_data   (rs1_data),
    .retire     (retire),
    .perf_event (perf_event),
    .csr_rdata  (csr_rdata)
);

initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
end

// --------------------------------------------------
// reference model
csr_pkg::arch_width_t m_mscratch;
csr_pkg::arch_width_t m_tohost;
logic [63:0] m_mcycle_base;
int m_mcycle_wcyc;
logic [63:0] m_minstret;
logic [63:0] m_hpm [csr_pkg::MHPMCOUNTERS];
csr_pkg::mhpmevent_t m_sel [csr_pkg::MHPMEVENTS];
csr_pkg::arch_width_t last_time;
int last_time_cyc;
// edges counted since reset release
int cyc;
bit rand_en;

function automatic logic [63:0] mcycle_now();
    mcycle_now = m_mcycle_base + 64'(cyc - m_mcycle_wcyc - 1);
endfunction

function automatic csr_pkg::arch_width_t model_read(input csr_pkg::csr_addr_t addr);
    logic [63:0] mc;
    mc = mcycle_now();
    model_read = '0;
    case (addr)
        csr_pkg::CSR_MSCRATCH: model_read = m_mscratch;
        csr_pkg::CSR_TOHOST: model_read = m_tohost;
        csr_pkg::CSR_MCYCLE: model_read = mc[31:0];
        csr_pkg::CSR_MCYCLEH: model_read = mc[63:32];
        csr_pkg::CSR_MINSTRET: model_read = m_minstret[31:0];
        csr_pkg::CSR_MINSTRETH: model_read = m_minstret[63:32];
        default: model_read = '0;
    endcase
    for (int i = 0; i < csr_pkg::MHPMCOUNTERS; i++) begin
        if (addr == csr_pkg::CSR_MHPMCOUNTER3 + 12'(i)) model_read = m_hpm[i][31:0];
        if (addr == csr_pkg::CSR_MHPMCOUNTER3H + 12'(i)) model_read = m_hpm[i][63:32];
        if (addr == csr_pkg::CSR_MHPMEVENT3 + 12'(i)) model_read = {26'd0, m_sel[i]};
    end
endfunction

// time is read only and ignores writes
function automatic void model_write(input csr_pkg::csr_addr_t addr,
                                    input csr_pkg::arch_width_t val);
    logic [63:0] mc;
    mc = mcycle_now();
    case (addr)
        csr_pkg::CSR_MSCRATCH: m_mscratch = val;
        csr_pkg::CSR_TOHOST: m_tohost = val;
        csr_pkg::CSR_MCYCLE: begin
            m_mcycle_base = {mc[63:32], val};
            m_mcycle_wcyc = cyc;
        end
        csr_pkg::CSR_MCYCLEH: begin
            m_mcycle_base = {val, mc[31:0]};
            m_mcycle_wcyc = cyc;
        end
        csr_pkg::CSR_MINSTRET: m_minstret[31:0] = val;
        csr_pkg::CSR_MINSTRETH: m_minstret[63:32] = val;
        default: ;
    endcase
    for (int i = 0; i < csr_pkg::MHPMCOUNTERS; i++) begin
        if (addr == csr_pkg::CSR_MHPMCOUNTER3 + 12'(i)) m_hpm[i][31:0] = val;
        if (addr == csr_pkg::CSR_MHPMCOUNTER3H + 12'(i)) m_hpm[i][63:32] = val;
        if (addr == csr_pkg::CSR_MHPMEVENT3 + 12'(i)) m_sel[i] = val[5:0];
    end
endfunction

function automatic string csr_name(input csr_pkg::csr_addr_t addr);
    case (addr)
        csr_pkg::CSR_MSCRATCH: csr_name = "mscratch";
        csr_pkg::CSR_TOHOST: csr_name = "tohost";
        csr_pkg::CSR_MCYCLE: csr_name = "mcycle";
        csr_pkg::CSR_MCYCLEH: csr_name = "mcycleh";
        csr_pkg::CSR_MINSTRET: csr_name = "minstret";
        csr_pkg::CSR_MINSTRETH: csr_name = "minstreth";
        csr_pkg::CSR_TIME: csr_name = "time";
        csr_pkg::CSR_TIMEH: csr_name = "timeh";
        default: begin
            if (addr[11:8] == 4'hB)
                csr_name = $sformatf("mhpmcounter%0d%s", addr[4:0], addr[7] ? "h" : "");
            else if (addr[11:4] == 8'h32)
                csr_name = $sformatf("mhpmevent%0d", addr[3:0]);
            else
                csr_name = $sformatf("csr 0x%03h", addr);
        end
    endcase
endfunction

// --------------------------------------------------
// failure reporting and checks
task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
endtask

task automatic check_data(input string name, input csr_pkg::arch_width_t got,
                          input csr_pkg::arch_width_t exp);
    if (got !== exp)
        abort_run($sformatf("CHECK FAILED at %0t: %s read 0x%08h, expected 0x%08h",
                            $time, name, got, exp));
endtask

task automatic check_event_sel(input string name, input csr_pkg::mhpmevent_t got,
                               input csr_pkg::mhpmevent_t exp);
    if (got !== exp)
        abort_run($sformatf("CHECK FAILED at %0t: %s selector 0x%02h, expected 0x%02h",
                            $time, name, got, exp));
endtask

task automatic check_time_step(input csr_pkg::arch_width_t step, input csr_pkg::arch_width_t lo,
                               input csr_pkg::arch_width_t hi);
    if (step < lo || step > hi)
        abort_run($sformatf("CHECK FAILED at %0t: time advanced by %0d, expected %0d to %0d",
                            $time, step, lo, hi));
endtask

// --------------------------------------------------
// stimulus
task automatic next_cycle();
    @(posedge clk);
    cyc++;
    if (cyc > MAX_CYCLES)
        abort_run($sformatf("simulation ran too long, over %0d cycles", MAX_CYCLES));
endtask

// pattern bit 6 drives retire and bits 5:0 the event pulses
task automatic idle_cycle(input logic [6:0] pattern);
    next_cycle();
    inst_valid <= 1'b0;
    retire <= pattern[6];
    perf_event <= pattern[5:0];
    if (pattern[6]) m_minstret++;
    for (int i = 0; i < csr_pkg::MHPMCOUNTERS; i++) begin
        if ($countones(m_sel[i]) == 1 && (m_sel[i] & pattern[5:0]) != '0) m_hpm[i]++;
    end
endtask

task automatic random_gap();
    int n;
    n = $urandom % 4;
    for (int k = 0; k < n; k++) begin
        idle_cycle(rand_en ? 7'($urandom) : 7'd0);
    end
endtask

// one instruction cycle with no pulses alongside it
task automatic run_inst(input logic [31:0] word, input csr_pkg::arch_width_t reg_val,
                        output csr_pkg::arch_width_t got, output csr_pkg::arch_width_t want);
    logic [2:0] f3;
    logic en;
    logic re;
    logic we;
    csr_pkg::arch_width_t old_val;
    csr_pkg::arch_width_t src;
    csr_pkg::arch_width_t new_val;
    f3 = word[14:12];
    en = (word[6:0] == 7'h73) && (f3 != 3'd0) && (f3 != 3'd4);
    re = en && !((f3[1:0] == 2'd1) && (word[11:7] == 5'd0));
    we = en && ((f3[1:0] == 2'd1) || (word[19:15] != 5'd0));
    src = f3[2] ? {27'd0, word[19:15]} : reg_val;
    next_cycle();
    inst_valid <= 1'b1;
    inst <= word;
    rs1_data <= reg_val;
    retire <= 1'b0;
    perf_event <= '0;
    old_val = model_read(word[31:20]);
    want = re ? old_val : '0;
    @(negedge clk);
    got = csr_rdata;
    case (f3[1:0])
        2'd1: new_val = src;
        2'd2: new_val = old_val | src;
        default: new_val = old_val & ~src;
    endcase
    if (we) model_write(word[31:20], new_val);
endtask

// --------------------------------------------------
// main sequence
initial begin
    int fd;
    int nlines;
    int nread;
    int gap;
    string line;
    string act;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    csr_pkg::arch_width_t got;
    csr_pkg::arch_width_t want;

    void'($urandom(22));
    rst = 1'b1;
    inst_valid = 1'b0;
    inst = '0;
    rs1_data = '0;
    retire = 1'b0;
    perf_event = '0;
    m_mscratch = '0;
    m_tohost = '0;
    m_mcycle_base = '0;
    m_mcycle_wcyc = -1;
    m_minstret = '0;
    for (int i = 0; i < csr_pkg::MHPMCOUNTERS; i++) begin
        m_hpm[i] = '0;
        m_sel[i] = csr_pkg::MHPMEVENT_NONE;
    end
    // the first edge after reset behaves like a read of time 0
    last_time = '0;
    last_time_cyc = 1;
    cyc = 0;
    rand_en = 1'b0;

    repeat (16) @(posedge clk);
    rst <= 1'b0;

    fd = $fopen("sim/csr_input.txt", "r");
    if (fd == 0) abort_run("could not open the input file sim/csr_input.txt");
    nlines = 0;
    while (!$feof(fd) && nlines < MAX_LINES) begin
        nlines++;
        nread = $fgets(line, fd);
        if (nread > 1 && line.getc(0) != "#") begin
            nread = $sscanf(line, "%s %h %h %h", act, a, b, c);
            if (nread != 4) abort_run($sformatf("input line %0d is malformed", nlines));
            random_gap();
            case (act)
                "x": begin
                    run_inst(a, b, got, want);
                    check_data(csr_name(a[31:20]), got, c);
                    check_data(csr_name(a[31:20]), got, want);
                end
                "s": begin
                    run_inst(a, b, got, want);
                    check_event_sel(csr_name(a[31:20]), got[5:0], c[5:0]);
                    check_data(csr_name(a[31:20]), got, want);
                end
                "m": begin
                    run_inst(a, b, got, want);
                    check_data(csr_name(a[31:20]), got, want);
                end
                "t": begin
                    run_inst(a, b, got, want);
                    gap = cyc - last_time_cyc;
                    check_time_step(got - last_time, gap / csr_pkg::CLOCKS_PER_US,
                                    (gap + csr_pkg::CLOCKS_PER_US - 1) / csr_pkg::CLOCKS_PER_US);
                    last_time = got;
                    last_time_cyc = cyc;
                end
                "p": begin
                    for (int k = 0; k < int'(b); k++) begin
                        idle_cycle(a[6:0]);
                    end
                end
                "r": rand_en = a[0];
                default: abort_run($sformatf("unknown action on input line %0d", nlines));
            endcase
        end
    end
    $fclose(fd);
    idle_cycle(7'd0);
    $display("Simulation finished: PASS");
    $finish;
end

endmodule

/* sim/csr_input.txt */
# columns: action, instruction or pulse pattern, rs1 value or cycle count, expected read (hex)
# x exact read, s selector read, m model read, t time read, p pulses (bit 6 retire), r random on/off
x 340020F3 00000000 00000000
x 51E020F3 00000000 00000000
m B00020F3 00000000 00000000
x B80020F3 00000000 00000000
x B02020F3 00000000 00000000
x B82020F3 00000000 00000000
x B03020F3 00000000 00000000
x B88020F3 00000000 00000000
s 323020F3 00000000 00000000
s 328020F3 00000000 00000000
x C81020F3 00000000 00000000
t C01020F3 00000000 00000000
x 340110B3 FFFFFFFF 00000000
x 340140F3 FFFFFFFF 00000000
x 340100F3 FFFFFFFF 00000000
x 340020F3 00000000 00000000
x 340110F3 A5A50F0F 00000000
x 340120F3 0000F000 A5A50F0F
x 340130F3 A500000F A5A5FF0F
x 340020F3 FFFFFFFF 00A5FF00
x 340030F3 FFFFFFFF 00A5FF00
x 340AD0F3 00000000 00A5FF00
x 340560F3 00000000 00000015
x 3401F0F3 00000000 0000001F
x 340060F3 00000000 0000001C
x 34011073 12345678 00000000
x 340020F3 00000000 12345678
x 51E110F3 DEADBEEF 00000000
x 51E0E0F3 00000000 DEADBEEF
x 51E7F0F3 00000000 DEADBEEF
x 51E130F3 FFFF0000 DEADBEE0
x 51E020F3 00000000 0000BEE0
x B8011073 00000007 00000000
x B0011073 FFFFFFF0 00000000
p 00 00000014 00000000
m B00020F3 00000000 00000000
m B80020F3 00000000 00000000
r 01 00000000 00000000
m B02020F3 00000000 00000000
p 40 00000005 00000000
m B02020F3 00000000 00000000
x B0211073 00000100 00000000
p 40 00000003 00000000
m B02020F3 00000000 00000000
m B82020F3 00000000 00000000
s 323150F3 00000000 00000000
s 325850F3 00000000 00000000
s 328110F3 00000020 00000000
s 323020F3 00000000 00000002
s 325020F3 00000000 00000010
s 328020F3 00000000 00000020
s 324020F3 00000000 00000000
x B0511073 00001000 00000000
p 3F 00000004 00000000
p 12 00000003 00000000
m B03020F3 00000000 00000000
m B04020F3 00000000 00000000
m B05020F3 00000000 00000000
m B08020F3 00000000 00000000
m B85020F3 00000000 00000000
p 00 0000001E 00000000
t C01020F3 00000000 00000000
t C01110F3 7FFF0000 00000000
p 00 0000003C 00000000
t C01020F3 00000000 00000000
x C81020F3 00000000 00000000

/* project.f */
hw/csr_pkg.sv
hw/csr_decode.sv
hw/csr_us_timer.sv
hw/csr_hpm_counters.sv
hw/csr_file.sv
hw/csr_unit_top.sv
sim/csr_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the csr unit testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module csr_unit_tb -o csr_unit_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/csr_unit_tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Simulation finished: PASS$"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
